// File: Makefile
# Verilator build and run of the cpuCore testbench
OBJ := obj_dir

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run tbCore"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module tbCore -f all.f -Mdir $(OBJ) -o simCore
	@out="$$(./$(OBJ)/simCore)"; echo "$$out"; echo "$$out" | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf $(OBJ)

// File: all.f
+incdir+mcrom
+incdir+testbench
common/mcPkg.sv
mcrom/mcRom.sv
logic/phaseSeq.sv
logic/dataPath.sv
logic/cpuCore.sv
testbench/tbCore.sv

// File: common/mcPkg.sv
`default_nettype none

package mcPkg;

	localparam int mcWidth = 20;
	localparam int mcSteps = 4;	// Exec steps, trailing bubble included
	localparam int stepBits = $clog2(mcSteps);

	typedef logic [5:0] phaseT;
	typedef logic [mcWidth-1:0] mcodeT;

	localparam phaseT phRst = 6'd0;
	localparam phaseT phVect = 6'd1;
	localparam phaseT phVec1 = 6'd2;
	localparam phaseT phVec2 = 6'd3;
	localparam phaseT phFetch = 6'd4;
	localparam phaseT phExec = 6'd5;
	localparam phaseT phExec1 = 6'd6;
	localparam phaseT phExec2 = 6'd7;
	localparam phaseT phExec3 = 6'd8;
	localparam phaseT phIntr = 6'd9;
	localparam phaseT phIntr1 = 6'd10;
	localparam phaseT phIntr2 = 6'd11;
	localparam phaseT phIntr3 = 6'd12;
	localparam phaseT phIntr4 = 6'd13;
	localparam phaseT phIntr5 = 6'd14;
	localparam phaseT phHalt = 6'd15;	// Highest defined code

	// Microword layout, op in the top bits and two spare bits at the bottom
	localparam int mcOpPos = 17;
	localparam int mcSrcPos = 14;
	localparam int mcDstPos = 11;
	localparam int mcAluPos = 9;
	localparam int mcAmPos = 6;
	localparam int mcPcPos = 4;
	localparam int mcLastBit = 3;
	localparam int mcHaltBit = 2;

	localparam logic [2:0] mcLd = 3'd0;
	localparam logic [2:0] mcPsh = 3'd1;	// Write to SP, then SP-1
	localparam logic [2:0] mcSt = 3'd2;
	localparam logic [2:0] mcAlu = 3'd3;
	localparam logic [2:0] mcNon = 3'd4;
	localparam logic [2:0] mcLdv = 3'd5;	// Vector select sits in src

	localparam logic [2:0] srcM = 3'd0;
	localparam logic [2:0] srcA = 3'd1;
	localparam logic [2:0] srcB = 3'd2;
	localparam logic [2:0] srcPl = 3'd3;
	localparam logic [2:0] srcPh = 3'd4;
	localparam logic [2:0] srcT = 3'd5;
	localparam logic [2:0] srcC = 3'd6;	// Flag register
	localparam logic [2:0] srcI = 3'd7;	// Constant zero

	// Destinations are written only by load and alu ops
	localparam logic [2:0] dstA = 3'd0;
	localparam logic [2:0] dstB = 3'd1;
	localparam logic [2:0] dstSh = 3'd2;
	localparam logic [2:0] dstSl = 3'd3;
	localparam logic [2:0] dstPh = 3'd4;
	localparam logic [2:0] dstPl = 3'd5;
	localparam logic [2:0] dstU = 3'd6;
	localparam logic [2:0] dstV = 3'd7;

	localparam logic [1:0] aluPass = 2'd0;
	localparam logic [1:0] aluAdd = 2'd1;	// A + source
	localparam logic [1:0] aluInc = 2'd2;

	localparam logic [2:0] amPC = 3'd0;
	localparam logic [2:0] amSP = 3'd1;
	localparam logic [2:0] amUV = 3'd2;
	localparam logic [2:0] amVh = 3'd3;
	localparam logic [2:0] amVl = 3'd4;

	localparam logic [1:0] pcHold = 2'd0;
	localparam logic [1:0] pcInc = 2'd1;
	localparam logic [1:0] pcLoad = 2'd2;	// PC from U:V

	localparam logic [2:0] vaRst = 3'd0;
	localparam logic [2:0] vaIrq = 3'd1;

	localparam logic [7:0] opLdaa = 8'h86;
	localparam logic [7:0] opLdab = 8'hC6;
	localparam logic [7:0] opLds = 8'h8E;
	localparam logic [7:0] opAba = 8'h1B;
	localparam logic [7:0] opInca = 8'h4C;
	localparam logic [7:0] opStaa = 8'hB7;
	localparam logic [7:0] opNop = 8'h01;

	localparam logic [15:0] vecReset = 16'hFFFE;
	localparam logic [15:0] vecIrq = 16'hFFF8;

	localparam int flagN = 3;	// 6801 CCR positions
	localparam int flagZ = 2;
	localparam int flagC = 0;

	function automatic mcodeT mw(
		input logic [2:0] op,
		input logic [2:0] src,
		input logic [2:0] dst,
		input logic [1:0] aluOp,
		input logic [2:0] am,
		input logic [1:0] pcCtl,
		input logic last,
		input logic halt
	);
		return {op, src, dst, aluOp, am, pcCtl, last, halt, 2'b00};
	endfunction

	localparam mcodeT mcNopWord = {mcNon, srcM, dstA, aluPass, amPC, pcHold, 1'b0, 1'b0, 2'b00};
	localparam mcodeT mcHaltWord = {mcNon, srcM, dstA, aluPass, amPC, pcHold, 1'b0, 1'b1, 2'b00};

endpackage

`default_nettype wire

// File: logic/cpuCore.sv
`default_nettype none

module cpuCore (
	input wire CLK,
	input wire reset,
	input wire irq,
	input wire [7:0] memRdata,
	output logic [15:0] memAddr,
	output logic [7:0] memWdata,
	output logic memWrite,
	output logic halted
);
	import mcPkg::*;

	phaseT phase;
	mcodeT mcode;
	logic [7:0] opcode;

	phaseSeq seq (
		.CLK(CLK),
		.reset(reset),
		.irq(irq),
		.memRdata(memRdata),
		.mcode(mcode),
		.phase(phase),
		.opcode(opcode),
		.halted(halted)
	);

	mcRom rom (
		.CLK(CLK),
		.phase(phase),
		.opcode(opcode),
		.mcode(mcode)
	);

	dataPath dp (
		.CLK(CLK),
		.reset(reset),
		.mcode(mcode),
		.memRdata(memRdata),
		.memAddr(memAddr),
		.memWdata(memWdata),
		.memWrite(memWrite)
	);

endmodule

`default_nettype wire

// File: logic/dataPath.sv
`default_nettype none

module dataPath (
	input wire CLK,
	input wire reset,
	input wire mcPkg::mcodeT mcode,
	input wire [7:0] memRdata,
	output logic [15:0] memAddr,
	output logic [7:0] memWdata,
	output logic memWrite
);
	import mcPkg::*;

	logic [2:0] op;
	logic [2:0] src;
	logic [2:0] dst;
	logic [1:0] aluOp;
	logic [2:0] am;
	logic [1:0] pcCtl;

	logic [15:0] pc;
	logic [15:0] sp;
	logic [7:0] ccr;
	logic [7:0] accA;
	logic [7:0] accB;
	logic [7:0] regT;	// Last written result
	logic [7:0] regU;
	logic [7:0] regV;
	logic [15:0] vecBase;

	logic [7:0] srcVal;
	logic [8:0] aluRes;
	logic writeDst;
	logic setNz;

	assign op = mcode[mcOpPos +: 3];
	assign src = mcode[mcSrcPos +: 3];
	assign dst = mcode[mcDstPos +: 3];
	assign aluOp = mcode[mcAluPos +: 2];
	assign am = mcode[mcAmPos +: 3];
	assign pcCtl = mcode[mcPcPos +: 2];

	always_comb begin
		case (src)
			srcM: srcVal = memRdata;
			srcA: srcVal = accA;
			srcB: srcVal = accB;
			srcPl: srcVal = pc[7:0];
			srcPh: srcVal = pc[15:8];
			srcT: srcVal = regT;
			srcC: srcVal = ccr;
			srcI: srcVal = 8'h00;
		endcase
		case (aluOp)
			aluAdd: aluRes = {1'b0, accA} + {1'b0, srcVal};	// Bit 8 is the carry
			aluInc: aluRes = {1'b0, srcVal} + 9'd1;
			default: aluRes = {1'b0, srcVal};
		endcase
		case (am)
			amSP: memAddr = sp;
			amUV: memAddr = {regU, regV};
			amVh: memAddr = vecBase;
			amVl: memAddr = {vecBase[15:1], 1'b1};
			default: memAddr = pc;
		endcase
	end

	assign writeDst = (op == mcLd) || (op == mcAlu);
	// Address and vector loads into U and V leave the flags alone
	assign setNz = (op == mcAlu) || ((op == mcLd) && (dst != dstU) && (dst != dstV));
	assign memWdata = srcVal;
	assign memWrite = (op == mcPsh) || (op == mcSt);

	always_ff @(posedge CLK) begin
		if (reset) begin
			pc <= 16'h0000;
			sp <= 16'h0000;
			ccr <= 8'h00;
		end else begin
			if (pcCtl == pcInc)
				pc <= pc + 16'd1;
			else if (pcCtl == pcLoad)
				pc <= {regU, regV};
			else if (writeDst && dst == dstPh)
				pc[15:8] <= aluRes[7:0];
			else if (writeDst && dst == dstPl)
				pc[7:0] <= aluRes[7:0];
			if (op == mcPsh)
				sp <= sp - 16'd1;	// Post-decrement push
			else if (writeDst && dst == dstSh)
				sp[15:8] <= aluRes[7:0];
			else if (writeDst && dst == dstSl)
				sp[7:0] <= aluRes[7:0];
			if (setNz) begin
				ccr[flagN] <= aluRes[7];
				ccr[flagZ] <= (aluRes[7:0] == 8'h00);
			end
			if (op == mcAlu && aluOp == aluAdd)
				ccr[flagC] <= aluRes[8];	// inc keeps C
		end
	end

	always_ff @(posedge CLK) begin
		if (writeDst) begin
			regT <= aluRes[7:0];
			case (dst)
				dstA: accA <= aluRes[7:0];
				dstB: accB <= aluRes[7:0];
				dstU: regU <= aluRes[7:0];
				dstV: regV <= aluRes[7:0];
				default: ;
			endcase
		end
		if (op == mcLdv)
			vecBase <= (src == vaIrq) ? vecIrq : vecReset;
	end

	// The ROM never pairs a halt word with a bus write
	assert property (@(posedge CLK) disable iff (reset) mcode[mcHaltBit] |-> !memWrite);

endmodule

`default_nettype wire

// File: logic/phaseSeq.sv
`default_nettype none

module phaseSeq (
	input wire CLK,
	input wire reset,
	input wire irq,
	input wire [7:0] memRdata,
	input wire mcPkg::mcodeT mcode,
	output mcPkg::phaseT phase,
	output logic [7:0] opcode,
	output logic halted
);
	import mcPkg::*;

	phaseT nextPhase;
	logic [7:0] opReg;	// Opcode of the running instruction
	logic mcLast;
	logic mcHalt;

	assign mcLast = mcode[mcLastBit];
	assign mcHalt = mcode[mcHaltBit];

	// The fetch word is on the bus while phExec is presented
	assign opcode = (phase == phExec) ? memRdata : opReg;
	assign halted = (phase == phHalt);

	// mcode belongs to the previous phase, so last is seen one step late
	always_comb begin
		nextPhase = phHalt;
		if (!mcHalt) begin
			case (phase)
				phRst: nextPhase = phVect;
				phVect: nextPhase = phVec1;
				phVec1: nextPhase = phVec2;
				phVec2: nextPhase = phFetch;
				phFetch: nextPhase = phExec;
				phExec, phExec1, phExec2, phExec3: begin
					if (mcLast)
						nextPhase = irq ? phIntr : phFetch;
					else if (phase != phExec3)
						nextPhase = phaseT'(phase + 6'd1);
				end
				phIntr, phIntr1, phIntr2, phIntr3, phIntr4: nextPhase = phaseT'(phase + 6'd1);
				phIntr5: nextPhase = phVect;	// Reuse vector load
				default: nextPhase = phHalt;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			phase <= phRst;
			opReg <= 8'h00;
		end else begin
			phase <= nextPhase;
			if (phase == phExec)
				opReg <= memRdata;
		end
	end

	// Exec steps never run past the last step table
	assert property (@(posedge CLK) disable iff (reset)
		(phase == phExec3) |-> (mcLast || mcHalt));

endmodule

`default_nettype wire

// File: mcrom/mcRom.sv
`default_nettype none

module mcRom (
	input wire CLK,
	input wire mcPkg::phaseT phase,
	input wire [7:0] opcode,
	output mcPkg::mcodeT mcode
);
	import mcPkg::*;

	`include "mcTables.svh"

	phaseT p;	// Phase seen by the select, one cycle behind
	mcodeT stepWord [mcSteps];
	logic [stepBits-1:0] stepIdx;

	always_ff @(posedge CLK) begin
		p <= phase;
	end

	// One registered table per exec step, all looked up every cycle
	for (genvar k = 0; k < mcSteps; k++) begin : genStep
		always_ff @(posedge CLK) begin
			stepWord[k] <= mcStep(k, opcode);
		end
	end

	assign stepIdx = stepBits'(p - phExec);

	always_comb begin
		case (p)
			phRst:
				mcode = mw(mcLdv, vaRst, dstA, aluPass, amPC, pcHold, 1'b0, 1'b0);
			phVect:
				mcode = mw(mcLd, srcM, dstU, aluPass, amVh, pcHold, 1'b0, 1'b0);
			phVec1:
				mcode = mw(mcLd, srcM, dstV, aluPass, amVl, pcHold, 1'b0, 1'b0);
			phVec2:
				mcode = mw(mcNon, srcM, dstA, aluPass, amPC, pcLoad, 1'b0, 1'b0);
			phFetch:
				mcode = mw(mcNon, srcM, dstA, aluPass, amPC, pcInc, 1'b0, 1'b0);	// Opcode read
			phExec, phExec1, phExec2, phExec3:
				mcode = stepWord[stepIdx];
			phIntr:
				mcode = mw(mcPsh, srcPl, dstA, aluPass, amSP, pcHold, 1'b0, 1'b0);
			phIntr1:
				mcode = mw(mcPsh, srcPh, dstA, aluPass, amSP, pcHold, 1'b0, 1'b0);
			phIntr2:
				mcode = mw(mcPsh, srcA, dstA, aluPass, amSP, pcHold, 1'b0, 1'b0);
			phIntr3:
				mcode = mw(mcPsh, srcB, dstA, aluPass, amSP, pcHold, 1'b0, 1'b0);
			phIntr4:
				mcode = mw(mcPsh, srcC, dstA, aluPass, amSP, pcHold, 1'b0, 1'b0);
			phIntr5:
				mcode = mw(mcLdv, vaIrq, dstA, aluPass, amPC, pcHold, 1'b0, 1'b0);
			default:
				mcode = mcHaltWord;	// phHalt and undefined codes
		endcase
	end

endmodule

`default_nettype wire

// File: mcrom/mcTables.svh
`ifndef mcTablesSvh
`define mcTablesSvh

function automatic logic mcKnown(input logic [7:0] opc);
	return opc inside {opLdaa, opLdab, opLds, opAba, opInca, opStaa, opNop};
endfunction

// Step 0 runs right after the fetch, PC already points past the opcode
function automatic mcodeT mcS0(input logic [7:0] opc);
	case (opc)
		opLdaa: return mw(mcLd, srcM, dstA, aluPass, amPC, pcInc, 1'b1, 1'b0);
		opLdab: return mw(mcLd, srcM, dstB, aluPass, amPC, pcInc, 1'b1, 1'b0);
		opLds: return mw(mcLd, srcM, dstSh, aluPass, amPC, pcInc, 1'b0, 1'b0);	// SP high
		opAba: return mw(mcAlu, srcB, dstA, aluAdd, amPC, pcHold, 1'b1, 1'b0);
		opInca: return mw(mcAlu, srcA, dstA, aluInc, amPC, pcHold, 1'b1, 1'b0);
		opStaa: return mw(mcLd, srcM, dstU, aluPass, amPC, pcInc, 1'b0, 1'b0);	// Addr high
		opNop: return mw(mcNon, srcM, dstA, aluPass, amPC, pcHold, 1'b1, 1'b0);
		default: return mcHaltWord;
	endcase
endfunction

function automatic mcodeT mcS1(input logic [7:0] opc);
	case (opc)
		opLds: return mw(mcLd, srcM, dstSl, aluPass, amPC, pcInc, 1'b1, 1'b0);
		opStaa: return mw(mcLd, srcM, dstV, aluPass, amPC, pcInc, 1'b0, 1'b0);	// Addr low
		default: return mcKnown(opc) ? mcNopWord : mcHaltWord;	// Bubble after last
	endcase
endfunction

function automatic mcodeT mcS2(input logic [7:0] opc);
	case (opc)
		opStaa: return mw(mcSt, srcA, dstA, aluPass, amUV, pcHold, 1'b1, 1'b0);
		default: return mcKnown(opc) ? mcNopWord : mcHaltWord;
	endcase
endfunction

// Only ever seen as the bubble behind STAA
function automatic mcodeT mcS3(input logic [7:0] opc);
	return mcKnown(opc) ? mcNopWord : mcHaltWord;
endfunction

function automatic mcodeT mcStep(input int step, input logic [7:0] opc);
	case (step)
		0: return mcS0(opc);
		1: return mcS1(opc);
		2: return mcS2(opc);
		3: return mcS3(opc);
		default: return mcHaltWord;
	endcase
endfunction

`endif

// File: testbench/tbModel.svh
`ifndef tbModelSvh
`define tbModelSvh

// Instruction-level model of the program in mem. It fills expAddr and expData
// and returns 1 when the program stops on an unsupported opcode
function automatic logic runModel(input int irqAt);
	logic [15:0] pc;
	logic [15:0] sp;
	logic [7:0] a;
	logic [7:0] b;
	logic [7:0] ccr;
	logic [7:0] opc;
	logic [7:0] res;
	logic [8:0] sum;
	logic [7:0] frame [5];
	logic setNz;
	logic armed;
	logic taken;
	logic stop;
	int steps;
	pc = {mem[vecReset], mem[vecReset + 16'd1]};
	sp = 16'h0000;
	a = 8'h00;
	b = 8'h00;
	ccr = 8'h00;
	res = 8'h00;
	armed = 1'b0;
	taken = 1'b0;
	stop = 1'b0;
	steps = 0;
	expAddr.delete();
	expData.delete();
	while (!stop && steps < 64) begin
		opc = mem[pc];
		pc = pc + 16'd1;
		setNz = 1'b1;
		case (opc)
			opLdaa: begin
				a = mem[pc];
				res = a;
				pc = pc + 16'd1;
			end
			opLdab: begin
				b = mem[pc];
				res = b;
				pc = pc + 16'd1;
			end
			opLds: begin
				sp = {mem[pc], mem[pc + 16'd1]};
				res = sp[7:0];	// Low byte is the last load
				pc = pc + 16'd2;
			end
			opAba: begin
				sum = {1'b0, a} + {1'b0, b};
				a = sum[7:0];
				res = a;
				ccr[flagC] = sum[8];
			end
			opInca: begin
				a = a + 8'd1;	// C untouched
				res = a;
			end
			opStaa: begin
				expAddr.push_back({mem[pc], mem[pc + 16'd1]});
				expData.push_back(a);
				pc = pc + 16'd2;
				setNz = 1'b0;
			end
			opNop: setNz = 1'b0;
			default: stop = 1'b1;
		endcase
		if (!stop) begin
			if (setNz) begin
				ccr[flagN] = res[7];
				ccr[flagZ] = (res == 8'h00);
			end
			// irq level is checked at the end of each instruction
			if (armed && !taken) begin
				frame = '{pc[7:0], pc[15:8], a, b, ccr};
				for (int i = 0; i < 5; i++) begin
					expAddr.push_back(sp - 16'(i));
					expData.push_back(frame[i]);
				end
				sp = sp - 16'd5;
				pc = {mem[vecIrq], mem[vecIrq + 16'd1]};
				taken = 1'b1;
			end
			armed = (irqAt > 0) && (expAddr.size() >= irqAt);
		end
		steps++;
	end
	return stop;
endfunction

`endif

// File: testbench/tbCore.sv
`default_nettype none

module tbCore;
	import mcPkg::*;

	localparam int clkPeriod = 10;
	localparam int numTests = 8;
	localparam int cyclesPerTest = 400;

	logic CLK;
	logic reset;
	logic irq;
	logic [7:0] memRdata;
	logic [15:0] memAddr;
	logic [7:0] memWdata;
	logic memWrite;
	logic halted;

	logic [7:0] mem [0:65535];
	logic [15:0] gotAddr [$];	// Write log of the memory model
	logic [7:0] gotData [$];
	logic [15:0] expAddr [$];
	logic [7:0] expData [$];
	logic [31:0] rngState;
	logic [15:0] asmPc;	// Next free program byte
	int logBase;	// First log entry of the running test
	int irqAfter;
	int errors;
	int passed;
	int failed;

	cpuCore dut (
		.CLK(CLK),
		.reset(reset),
		.irq(irq),
		.memRdata(memRdata),
		.memAddr(memAddr),
		.memWdata(memWdata),
		.memWrite(memWrite),
		.halted(halted)
	);

	assign memRdata = mem[memAddr];

	always @(posedge CLK) begin
		if (!reset && memWrite) begin
			gotAddr.push_back(memAddr);
			gotData.push_back(memWdata);
		end
	end

	`include "tbModel.svh"

	initial begin
		CLK = 1'b0;
		forever #(clkPeriod / 2) CLK = ~CLK;
	end

	initial begin
		#(numTests * cyclesPerTest * clkPeriod);
		$display("watchdog: run exceeded %0d cycles", numTests * cyclesPerTest);
		$display("CHECKS FAILED");
		$finish;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [7:0] randByte();
		rngState = xorshift(rngState);
		return rngState[15:8];
	endfunction

	task automatic checkAddr(input string name, input logic [15:0] got, input logic [15:0] exp);
		if (got !== exp) begin
			$display("MISMATCH %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic checkData(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			$display("MISMATCH %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic checkHalted(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("MISMATCH %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic emit(input logic [7:0] b);
		mem[asmPc] = b;
		asmPc = asmPc + 16'd1;
	endtask

	task automatic emitWord(input logic [7:0] op, input logic [15:0] w);
		emit(op);
		emit(w[15:8]);	// Big endian operand
		emit(w[7:0]);
	endtask

	task automatic newProgram(input logic [15:0] org, input logic [15:0] irqVec);
		for (int i = 0; i < 65536; i++)
			mem[16'(i)] = 8'(i ^ (i >> 8)) ^ 8'hA5;
		mem[vecReset] = org[15:8];
		mem[vecReset + 16'd1] = org[7:0];
		mem[vecIrq] = irqVec[15:8];
		mem[vecIrq + 16'd1] = irqVec[7:0];
		asmPc = org;
	endtask

	// irq goes high after the given write and drops once the five pushes are done
	task automatic stepCycle();
		int n;
		@(posedge CLK);
		#1;
		n = gotAddr.size() - logBase;
		irq = (irqAfter > 0) && (n >= irqAfter) && (n < irqAfter + 5);
	endtask

	task automatic runTest(input string name, input int irqAt);
		int errBefore;
		int n;
		logic expHalt;
		errBefore = errors;
		expHalt = runModel(irqAt);
		irqAfter = irqAt;
		logBase = gotAddr.size();
		reset = 1'b1;
		irq = 1'b0;
		repeat (2) stepCycle();
		reset = 1'b0;
		n = 0;
		// Pass over the reads of 0000, FFFE and FFFF before the first fetch
		while ((memAddr == 16'h0000 || memAddr >= vecReset) && n < 20) begin
			stepCycle();
			n++;
		end
		checkAddr("memAddr", memAddr, {mem[vecReset], mem[vecReset + 16'd1]});
		n = 0;
		while (!halted && n < cyclesPerTest - 100) begin
			stepCycle();
			n++;
		end
		if (!halted) begin
			$display("%s: core did not halt within %0d cycles", name, n);
			errors++;
		end
		repeat (50) stepCycle();
		checkHalted("halted", halted, expHalt);
		n = gotAddr.size() - logBase;
		if (n != expAddr.size()) begin
			$display("%s: saw %0d memory writes, expected %0d", name, n, expAddr.size());
			errors++;
		end
		for (int i = 0; i < n && i < expAddr.size(); i++) begin
			checkAddr("memAddr", gotAddr[logBase + i], expAddr[i]);
			checkData("memWdata", gotData[logBase + i], expData[i]);
		end
		if (errors == errBefore) begin
			passed++;
			$display("test %s: ok", name);
		end else begin
			failed++;
			$display("test %s: %0d errors", name, errors - errBefore);
		end
	endtask

	initial begin
		logic [15:0] org;
		logic [15:0] dst;
		logic [15:0] handler;
		logic [7:0] x;
		logic [7:0] y;
		rngState = 32'h98ab_4161;
		reset = 1'b1;
		irq = 1'b0;
		irqAfter = 0;
		logBase = 0;
		errors = 0;
		passed = 0;
		failed = 0;
		asmPc = 16'h0000;

		org = {8'h01, randByte()};
		newProgram(org, 16'h2000);
		emit(opNop);
		emit(8'h00);	// Unsupported, stops the core
		runTest("reset vector", 0);

		for (int k = 0; k < 4; k++) begin
			org = {4'h1, 4'(k), randByte()};
			dst = {4'h8, randByte(), 4'h0};
			x = randByte();
			y = randByte();
			newProgram(org, 16'h2000);
			emit(opLdaa);
			emit(x);
			emit(opLdab);
			emit(y);
			emit(opAba);
			emitWord(opStaa, dst);
			emit(8'h00);
			runTest($sformatf("sum %0d", k), 0);
		end

		newProgram(16'h0300, 16'h2000);
		emit(opLdaa);
		emit(8'hFF);
		emit(opInca);
		emitWord(opStaa, 16'h8100);
		emit(8'h00);
		runTest("inca wrap", 0);

		handler = {4'h2, randByte(), 4'h0};
		dst = {4'h8, randByte(), 4'h0};
		x = randByte();
		y = randByte() | 8'h80;	// Sets N before the pushes
		newProgram(16'h0400, handler);
		emitWord(opLds, {4'h4, randByte(), 4'h8});
		emit(opLdaa);
		emit(x);
		emit(opLdab);
		emit(y);
		emitWord(opStaa, dst);
		emit(opNop);
		emit(8'h00);
		asmPc = handler;
		emitWord(opStaa, dst + 16'd1);
		emit(8'h00);
		runTest("irq entry", 1);

		newProgram(16'h0500, 16'h2000);
		emit(opLdaa);
		emit(randByte());
		emitWord(opStaa, 16'h8200);
		emit(8'h3F);
		emitWord(opStaa, 16'h8201);	// Never reached
		runTest("bad opcode", 0);

		$display("tests %0d, passed %0d, failed %0d, errors %0d",
			passed + failed, passed, failed, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire
